//--- Bender.yml
package:
  name: proc_top

sources:
  - design/proc_pkg.sv
  - design/stage_if.sv
  - design/fetch.sv
  - design/decode.sv
  - design/hazard_unit.sv
  - design/execute.sv
  - design/mem_stage.sv
  - design/proc_top.sv
  - target: test
    files:
      - bench/proc_top_tb.sv

//--- bench/proc_top_tb.sv
// Table-driven testbench that loads programs into the pipelined core over APB and runs them
// Each table row runs one short program and reads its result words from data memory
`timescale 1ns/10ps

module proc_top_tb;
   import proc_pkg::*;

   localparam int    NROWS    = 22;
   localparam int    LIMIT    = 200 * NROWS + 500;   // Cycles
   localparam int    PROG_LEN = 16;
   localparam word_t MARK     = 16'h0007;
   localparam word_t HALT_WORD = {OP_HALT, 11'd0};
   localparam word_t ILL_WORD  = 16'hF800;          // Opcode 11111 is unassigned

   // Row kinds
   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_XOR  = 3;
   localparam int K_ADDI = 4;
   localparam int K_BEQZ = 5;
   localparam int K_BNEZ = 6;
   localparam int K_J    = 7;
   localparam int K_BUSY = 8;
   localparam int K_ILL  = 9;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [11:0] paddr;
   word_t       pwdata;
   word_t       prdata;
   logic        pready;
   logic        pslverr;
   logic        err;

   int         row_kind [NROWS];
   word_t      row_a    [NROWS];
   word_t      row_b    [NROWS];
   logic [4:0] row_imm  [NROWS];      // Skip count for branch rows
   int         row_gap  [NROWS];      // NOPs between dependent words
   word_t      row_init [NROWS];
   word_t      row_exp2 [NROWS];
   word_t      row_exp3 [NROWS];

   word_t prog [PROG_LEN];
   int    plen;
   int    seed;
   int    errors;
   int    checks;
   int    cycles;
   int    cur_row;
   logic  err_exp;

   proc_top DUT (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .err(err));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic word_t sext5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic word_t alu_expect(int kind, word_t a, word_t b, logic [4:0] imm);
      word_t r;
      case (kind)
         K_ADD:   r = a + b;
         K_SUB:   r = a - b;
         K_AND:   r = a & b;
         K_XOR:   r = a ^ b;
         default: r = a + sext5(imm);
      endcase
      return r;
   endfunction

   function automatic logic branch_taken(int kind, word_t a);
      return (kind == K_J) || (kind == K_BEQZ && a == '0) || (kind == K_BNEZ && a != '0);
   endfunction

   function automatic word_t enc_rr(logic [1:0] func, reg_sel_t rs, reg_sel_t rt, reg_sel_t rd);
      return {OP_RR, rs, rt, rd, func};
   endfunction

   function automatic word_t enc_imm(opcode_t op, reg_sel_t rs, reg_sel_t rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic value_error(string name, word_t got, word_t exp);
      errors++;
      $display("** Error: %s = 0x%04h, expected 0x%04h (row %0d)", name, got, exp, cur_row);
   endtask

   task automatic set_row(int i, int kind, word_t a, word_t b, logic [4:0] imm, int gap);
      row_kind[i] = kind;
      row_a[i]    = a;
      row_b[i]    = b;
      row_imm[i]  = imm;
      row_gap[i]  = gap;
      row_exp3[i] = '0;
      if (kind <= K_ADDI) begin
         row_exp2[i] = alu_expect(kind, a, b, imm);
         row_init[i] = ~row_exp2[i];           // A lost store cannot match
      end else if (kind <= K_J) begin
         row_exp2[i] = branch_taken(kind, a) ? '0 : MARK;
         row_exp3[i] = MARK;
         row_init[i] = '0;
      end else begin
         row_exp2[i] = a;                       // Old value must survive
         row_init[i] = a;
      end
   endtask

   task automatic build_table();
      word_t      a;
      word_t      b;
      logic [4:0] imm;
      set_row(0,  K_ADD,  16'h7FFF, 16'h0001, 5'd0,  0);
      set_row(1,  K_ADD,  16'hFFFF, 16'hFFFF, 5'd0,  3);
      set_row(2,  K_SUB,  16'h0000, 16'hFFFF, 5'd0,  0);
      set_row(3,  K_AND,  16'hFFFF, 16'h7FFF, 5'd0,  0);
      set_row(4,  K_XOR,  16'h7FFF, 16'hFFFF, 5'd0,  3);
      set_row(5,  K_ADDI, 16'h7FFF, 16'h0000, 5'd1,  0);
      set_row(6,  K_ADDI, 16'h0000, 16'h0000, 5'h1F, 0);
      set_row(7,  K_BEQZ, 16'h0000, 16'h0000, 5'd1,  0);
      set_row(8,  K_BEQZ, 16'h7FFF, 16'h0000, 5'd1,  3);
      set_row(9,  K_BNEZ, 16'h0000, 16'h0000, 5'd2,  0);
      set_row(10, K_BNEZ, 16'hFFFF, 16'h0000, 5'd2,  0);
      set_row(11, K_J,    16'h0000, 16'h0000, 5'd2,  0);
      set_row(12, K_BUSY, 16'h1234, 16'hBEEF, 5'd0,  0);
      set_row(13, K_ILL,  16'h00A5, 16'h0000, 5'd0,  0);
      for (int i = 14; i < NROWS; i++) begin
         a   = word_t'($random(seed));
         b   = word_t'($random(seed));
         imm = 5'($random(seed));
         set_row(i, (i - 14) % 5, a, b, imm, (i % 2) * 3);
      end
   endtask

   task automatic emit(word_t w);
      prog[plen] = w;
      plen++;
   endtask

   task automatic emit_nops(int n);
      for (int k = 0; k < n; k++)
         emit(NOP_WORD);
   endtask

   // Operands load from dmem[0] and dmem[1] and results go to dmem[2] and dmem[3]
   task automatic build_program(int i);
      int         kind;
      logic [1:0] func;
      kind = row_kind[i];
      plen = 0;
      if (kind <= K_ADDI) begin
         case (kind)
            K_SUB:   func = ALU_SUB;
            K_AND:   func = ALU_AND;
            K_XOR:   func = ALU_XOR;
            default: func = ALU_ADD;
         endcase
         emit(enc_imm(OP_LD, 3'd0, 3'd1, 5'd0));
         if (kind != K_ADDI)
            emit(enc_imm(OP_LD, 3'd0, 3'd2, 5'd1));
         emit_nops(row_gap[i]);
         if (kind == K_ADDI)
            emit(enc_imm(OP_ADDI, 3'd1, 3'd3, row_imm[i]));
         else
            emit(enc_rr(func, 3'd1, 3'd2, 3'd3));
         emit_nops(row_gap[i]);
         emit(enc_imm(OP_ST, 3'd0, 3'd3, 5'd2));
      end else if (kind <= K_J) begin
         emit(enc_imm(OP_LD, 3'd0, 3'd1, 5'd0));
         emit(enc_imm(OP_ADDI, 3'd0, 3'd4, MARK[4:0]));    // Marker into r4
         emit_nops(row_gap[i]);
         if (kind == K_J)
            emit({OP_J, 6'd0, row_imm[i]});
         else
            emit(enc_imm(kind == K_BEQZ ? OP_BEQZ : OP_BNEZ, 3'd1, 3'd0, row_imm[i]));
         for (int k = 0; k < row_imm[i]; k++)
            emit(enc_imm(OP_ST, 3'd0, 3'd4, 5'd2));       // Shadow of the branch
         emit(enc_imm(OP_ST, 3'd0, 3'd4, 5'd3));
      end else if (kind == K_BUSY) begin
         emit_nops(8);               // Keeps the core busy during the blocked write
      end else begin
         emit(ILL_WORD);
         emit(NOP_WORD);
      end
      emit(HALT_WORD);
   endtask

   task automatic apb_write(logic [11:0] addr, word_t data, output logic slverr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      slverr = pslverr;
      checks++;
      if (pready !== 1'b1)
         value_error("pready", pready, 16'h1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(logic [11:0] addr, output word_t data, output logic slverr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);                // Middle of the access cycle
      data   = prdata;
      slverr = pslverr;
      checks++;
      if (pready !== 1'b1)
         value_error("pready", pready, 16'h1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic bus_write(logic [11:0] addr, word_t data);
      logic se;
      apb_write(addr, data, se);
      checks++;
      if (se !== 1'b0)
         value_error("pslverr", se, 16'h0);
   endtask

   task automatic bus_read(logic [11:0] addr, output word_t data);
      logic se;
      apb_read(addr, data, se);
      checks++;
      if (se !== 1'b0)
         value_error("pslverr", se, 16'h0);
   endtask

   task automatic run_row(int i);
      word_t rd;
      logic  se;
      cur_row = i;
      build_program(i);
      for (int k = 0; k < PROG_LEN; k++)
         bus_write(12'(IMEM_BASE + k), (k < plen) ? prog[k] : HALT_WORD);
      bus_write(12'(DMEM_BASE + 0), row_a[i]);
      bus_write(12'(DMEM_BASE + 1), row_b[i]);
      bus_write(12'(DMEM_BASE + 2), row_init[i]);
      bus_write(12'(DMEM_BASE + 3), 16'h0000);
      bus_write(CTRL_ADDR, 16'h0001);
      if (row_kind[i] == K_BUSY) begin
         apb_write(12'(DMEM_BASE + 2), row_b[i], se);
         checks++;
         if (se !== 1'b1)
            value_error("pslverr", se, 16'h1);
      end
      if (row_kind[i] == K_ILL)
         err_exp = 1'b1;
      rd = '0;
      while (rd[1] !== 1'b1)
         bus_read(CTRL_ADDR, rd);
      checks++;
      if (rd !== 16'h0002)         // Halted set and run cleared
         value_error("ctrl", rd, 16'h0002);
      bus_read(12'(DMEM_BASE + 2), rd);
      checks++;
      if (rd !== row_exp2[i])
         value_error("dmem[2]", rd, row_exp2[i]);
      bus_read(12'(DMEM_BASE + 3), rd);
      checks++;
      if (rd !== row_exp3[i])
         value_error("dmem[3]", rd, row_exp3[i]);
      checks++;
      if (err !== err_exp)
         value_error("err", err, err_exp);
   endtask

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the core or the bus did not finish within %0d cycles", LIMIT);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("test failed");
      $finish;
   end

   initial begin
      word_t rd;
      logic  se;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed    = 23;
      errors  = 0;
      checks  = 0;
      cur_row = 0;
      err_exp = 1'b0;
      build_table();
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      for (int i = 0; i < NROWS; i++)
         run_row(i);

      cur_row = NROWS;
      apb_read(12'h200, rd, se);        // Hole between the memory windows
      checks++;
      if (se !== 1'b1)
         value_error("pslverr", se, 16'h1);

      // Sticky err only clears with reset
      @(posedge clk);
      rst <= 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checks++;
      if (err !== 1'b0)
         value_error("err", err, 16'h0);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- design/decode.sv
// Decode stage with control decode, register file and the decode-to-execute register
// Write-back enters through the mw bundle and bypasses into the same-cycle read
`timescale 1ns/10ps

module decode (
   input  logic               clk,
   input  logic               rst,
   input  proc_pkg::instr_t   instr_d,
   input  proc_pkg::word_t    pc_d,
   input  logic               stall,
   input  logic               bubble,
   input  logic               flush,
   mw_if.dst                  wb,
   de_if.src                  de,
   output proc_pkg::reg_sel_t rs_sel,
   output proc_pkg::reg_sel_t rt_sel,
   output logic               uses_rt,
   output logic               err
);
   import proc_pkg::*;

   word_t    regs [8];
   opcode_t  op;
   ctrl_t    ctrl_dec;
   ctrl_t    ctrl_d;
   reg_sel_t dest;
   word_t    imm_ext;
   logic     is_rr;
   logic     legal;
   logic     halt_seen;          // HALT has passed, younger words are dead

   function automatic word_t read_reg(reg_sel_t sel);
      word_t val;
      if (sel == '0)
         val = '0;
      else if (wb.reg_write && wb.dest == sel)
         val = wb.data;
      else
         val = regs[sel];
      return val;
   endfunction

   assign op     = instr_d.r_fmt.opcode;
   assign rs_sel = instr_d.r_fmt.rs;
   assign rt_sel = instr_d.r_fmt.rt;

   always_comb begin
      ctrl_dec = '0;
      legal    = 1'b1;
      is_rr    = 1'b0;
      uses_rt  = 1'b0;
      imm_ext  = {{11{instr_d.i_fmt.imm[4]}}, instr_d.i_fmt.imm};
      case (op)
         OP_NOP: ;
         OP_HALT: ctrl_dec.halt = 1'b1;
         OP_RR: begin
            ctrl_dec.reg_write = 1'b1;
            is_rr              = 1'b1;
            uses_rt            = 1'b1;
         end
         OP_ADDI: begin
            ctrl_dec.reg_write = 1'b1;
            ctrl_dec.alu_src   = 1'b1;
         end
         OP_LD: begin
            ctrl_dec.reg_write = 1'b1;
            ctrl_dec.mem_read  = 1'b1;
            ctrl_dec.alu_src   = 1'b1;
         end
         OP_ST: begin
            ctrl_dec.mem_write = 1'b1;
            ctrl_dec.alu_src   = 1'b1;
            uses_rt            = 1'b1;      // Store data
         end
         OP_BEQZ: ctrl_dec.branch = BR_EQZ;
         OP_BNEZ: ctrl_dec.branch = BR_NEZ;
         OP_J: begin
            ctrl_dec.jump = 1'b1;
            imm_ext       = {{5{instr_d[10]}}, instr_d[10:0]};
         end
         default: legal = 1'b0;               // Behaves as NOP
      endcase
   end

   assign dest = is_rr ? instr_d.r_fmt.rd : instr_d.i_fmt.rt;

   // r0 is never written
   always_comb begin
      ctrl_d           = ctrl_dec;
      ctrl_d.reg_write = ctrl_dec.reg_write && (dest != '0);
   end

   always_ff @(posedge clk) begin
      if (wb.reg_write)
         regs[wb.dest] <= wb.data;
   end

   always_ff @(posedge clk) begin
      if (rst || flush || bubble || halt_seen)
         de.ctrl <= '0;
      else
         de.ctrl <= ctrl_d;
   end

   always_ff @(posedge clk) begin
      de.op      <= op;
      de.func    <= instr_d.r_fmt.func;
      de.rs_data <= read_reg(rs_sel);
      de.rt_data <= read_reg(rt_sel);
      de.imm     <= imm_ext;
      de.dest    <= dest;
      de.pc      <= pc_d;
   end

   always_ff @(posedge clk) begin
      if (rst || flush)
         halt_seen <= 1'b0;
      else if (ctrl_d.halt && !stall)
         halt_seen <= 1'b1;
   end

   // Sticky until reset, counted only when the word actually leaves decode
   always_ff @(posedge clk) begin
      if (rst)
         err <= 1'b0;
      else if (!legal && !stall && !flush && !halt_seen)
         err <= 1'b1;
   end

   a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
      wb.reg_write |-> wb.dest != '0)
      else $error("register write addressed to r0 reached write-back");

endmodule

//--- design/execute.sv
// Execute stage with ALU, zero test for branches and the execute-to-memory register
// A taken branch or jump redirects fetch and flushes decode in the same cycle
`timescale 1ns/10ps

module execute (
   input  logic            clk,
   input  logic            rst,
   de_if.dst               de,
   em_if.src               em,
   output logic            redirect,
   output proc_pkg::word_t redirect_pc,
   output logic            flush
);
   import proc_pkg::*;

   alu_op_t alu_op;
   word_t   op_b;
   word_t   alu_out;
   logic    zero;

   assign alu_op = (de.op == OP_RR) ? alu_op_t'(de.func) : ALU_ADD;   // Address and ADDI add
   assign op_b   = de.ctrl.alu_src ? de.imm : de.rt_data;

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_out = de.rs_data + op_b;
         ALU_SUB: alu_out = de.rs_data - op_b;
         ALU_AND: alu_out = de.rs_data & op_b;
         default: alu_out = de.rs_data ^ op_b;
      endcase
   end

   assign zero        = (de.rs_data == '0);
   assign redirect    = de.ctrl.jump ||
                        (de.ctrl.branch == BR_EQZ && zero) ||
                        (de.ctrl.branch == BR_NEZ && !zero);
   assign redirect_pc = de.pc + 16'd1 + de.imm;
   assign flush       = redirect;

   always_ff @(posedge clk) begin
      if (rst)
         em.ctrl <= '0;
      else
         em.ctrl <= de.ctrl;
   end

   always_ff @(posedge clk) begin
      em.alu_result <= alu_out;
      em.store_data <= de.rt_data;
      em.dest       <= de.dest;
   end

   // Word behind a taken branch must arrive as a bubble
   a_redirect_flush: assert property (@(posedge clk) disable iff (rst)
      redirect |-> (de.ctrl.jump || de.ctrl.branch != BR_NONE) ##1 (de.ctrl == '0))
      else $error("redirect without flush of the younger word");

endmodule

//--- design/fetch.sv
// Fetch stage with PC, instruction memory and the fetch-to-decode register
// Instruction memory is loaded over APB while the core is idle
`timescale 1ns/10ps

module fetch #(
   parameter int IMEM_AW = proc_pkg::IMEM_AW
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  logic                 stall,
   input  logic                 redirect,
   input  proc_pkg::word_t      redirect_pc,
   input  logic                 imem_we,
   input  logic [IMEM_AW-1:0]   imem_addr,
   input  proc_pkg::word_t      imem_wdata,
   output proc_pkg::instr_t     instr_d,
   output proc_pkg::word_t      pc_d
);
   import proc_pkg::*;

   word_t imem [2**IMEM_AW];
   word_t pc;

   always_ff @(posedge clk) begin
      if (imem_we)
         imem[imem_addr] <= imem_wdata;
   end

   // Redirect and start both discard the word fetched this cycle
   always_ff @(posedge clk) begin
      if (rst || start) begin
         pc      <= '0;
         pc_d    <= '0;
         instr_d <= NOP_WORD;
      end else if (redirect) begin
         pc      <= redirect_pc;
         pc_d    <= '0;
         instr_d <= NOP_WORD;
      end else if (!stall) begin
         pc      <= pc + 16'd1;                // Word addressed
         pc_d    <= pc;
         instr_d <= imem[pc[IMEM_AW-1:0]];
      end
   end

endmodule

//--- design/hazard_unit.sv
// Register dependency check between decode and the three younger pipeline registers
// A match holds fetch and decode and sends a bubble into execute
`timescale 1ns/10ps

module hazard_unit (
   input  logic               clk,
   input  logic               rst,
   input  proc_pkg::reg_sel_t rs_sel,
   input  proc_pkg::reg_sel_t rt_sel,
   input  logic               uses_rt,
   de_if.monitor              de,
   em_if.monitor              em,
   mw_if.monitor              mw,
   output logic               stall,
   output logic               bubble
);
   import proc_pkg::*;

   // r0 never carries reg_write, so a zero source field never matches
   function automatic logic hit(reg_sel_t dest, logic wr);
      return wr && (dest == rs_sel || (uses_rt && dest == rt_sel));
   endfunction

   assign stall = hit(de.dest, de.ctrl.reg_write) ||
                  hit(em.dest, em.ctrl.reg_write) ||
                  hit(mw.dest, mw.reg_write);
   assign bubble = stall;

   // Producer is gone from write-back after at most three bubbles
   a_stall_bound: assert property (@(posedge clk) disable iff (rst)
      bubble [*3] |=> !stall)
      else $error("dependency stall longer than the pipeline depth");

endmodule

//--- design/mem_stage.sv
// Memory stage with the data memory, the memory-to-writeback register and write-back select
// The single memory port belongs to the core while run is set and to APB otherwise
`timescale 1ns/10ps

module mem_stage #(
   parameter int DMEM_AW = proc_pkg::DMEM_AW
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   em_if.dst                  em,
   mw_if.src                  wb,
   input  logic               dmem_we,
   input  logic [DMEM_AW-1:0] dmem_addr,
   input  proc_pkg::word_t    dmem_wdata,
   output proc_pkg::word_t    dmem_rdata,
   output logic               halt_wb
);
   import proc_pkg::*;

   word_t              dmem [2**DMEM_AW];
   logic [DMEM_AW-1:0] addr;
   logic               we;
   word_t              wdata;
   word_t              rdata_q;
   word_t              alu_q;
   logic               load_q;

   assign addr  = run ? em.alu_result[DMEM_AW-1:0] : dmem_addr;
   assign we    = run ? em.ctrl.mem_write : dmem_we;
   assign wdata = run ? em.store_data : dmem_wdata;

   always_ff @(posedge clk) begin
      if (we)
         dmem[addr] <= wdata;
      rdata_q <= dmem[addr];      // Ready in the next cycle
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.reg_write <= 1'b0;
         load_q       <= 1'b0;
         halt_wb      <= 1'b0;
      end else begin
         wb.reg_write <= em.ctrl.reg_write;
         load_q       <= em.ctrl.mem_read;
         halt_wb      <= em.ctrl.halt;
      end
   end

   always_ff @(posedge clk) begin
      alu_q   <= em.alu_result;
      wb.dest <= em.dest;
   end

   assign wb.data    = load_q ? rdata_q : alu_q;
   assign dmem_rdata = rdata_q;

endmodule

//--- design/proc_pkg.sv
// Opcodes, instruction formats, control word and APB address map of the 16-bit core
// Imported by every design file and the testbench
package proc_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_RR   = 5'b11011      // ADD, SUB, AND, XOR by func field
   } opcode_t;

   // Encoding matches the func field of register format
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_AND = 2'b10,
      ALU_XOR = 2'b11
   } alu_op_t;

   typedef union packed {
      struct packed {
         opcode_t    opcode;
         reg_sel_t   rs;
         reg_sel_t   rt;
         reg_sel_t   rd;
         logic [1:0] func;
      } r_fmt;
      struct packed {
         opcode_t    opcode;
         reg_sel_t   rs;
         reg_sel_t   rt;     // Destination for ADDI and LD, store data for ST
         logic [4:0] imm;
      } i_fmt;
   } instr_t;

   typedef struct packed {
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
      logic       alu_src;
      logic [1:0] branch;
      logic       jump;
      logic       halt;
   } ctrl_t;

   localparam logic [1:0] BR_NONE = 2'b00;
   localparam logic [1:0] BR_EQZ  = 2'b01;
   localparam logic [1:0] BR_NEZ  = 2'b10;

   localparam word_t NOP_WORD = {OP_NOP, 11'd0};

   localparam int IMEM_AW = 8;
   localparam int DMEM_AW = 8;

   // APB map, each memory window is 512 words
   localparam int          WIN_LSB   = 9;
   localparam logic [11:0] IMEM_BASE = 12'h000;
   localparam logic [11:0] DMEM_BASE = 12'h400;
   localparam logic [11:0] CTRL_ADDR = 12'h800;

endpackage

//--- design/proc_top.sv
// Top level of the pipelined core with its APB slave port
// APB loads the memories, starts the core and reads back halted
`timescale 1ns/10ps

module proc_top #(
   parameter int IMEM_AW = proc_pkg::IMEM_AW,
   parameter int DMEM_AW = proc_pkg::DMEM_AW
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  logic [11:0]     paddr,
   input  proc_pkg::word_t pwdata,
   output proc_pkg::word_t prdata,
   output logic            pready,
   output logic            pslverr,
   output logic            err
);
   import proc_pkg::*;

   logic     run;
   logic     halted;
   logic     access;
   logic     sel_imem, sel_dmem, sel_ctrl;
   logic     ctrl_we, start, hold, kill;
   logic     imem_we, dmem_we;
   word_t    dmem_rdata;
   logic     halt_wb;
   logic     stall, bubble, redirect, flush;
   word_t    redirect_pc;
   instr_t   instr_d;
   word_t    pc_d;
   reg_sel_t rs_sel, rt_sel;
   logic     uses_rt;

   de_if de_bus ();
   em_if em_bus ();
   mw_if mw_bus ();

   assign access   = psel && penable;
   assign sel_imem = (paddr[11:WIN_LSB] == IMEM_BASE[11:WIN_LSB]);
   assign sel_dmem = (paddr[11:WIN_LSB] == DMEM_BASE[11:WIN_LSB]);
   assign sel_ctrl = (paddr == CTRL_ADDR);

   // Unmapped, or a memory touched while the core owns it
   assign pslverr = access && (!(sel_imem || sel_dmem || sel_ctrl) ||
                               ((sel_imem || sel_dmem) && run));
   assign pready  = 1'b1;
   assign imem_we = access && pwrite && sel_imem && !run;
   assign dmem_we = access && pwrite && sel_dmem && !run;
   assign ctrl_we = access && pwrite && sel_ctrl;
   assign start   = ctrl_we && pwdata[0];
   assign hold    = stall || !run;     // Idle core holds fetch and feeds bubbles
   assign kill    = bubble || !run;

   always_ff @(posedge clk) begin
      if (rst) begin
         run    <= 1'b0;
         halted <= 1'b0;
      end else if (ctrl_we) begin
         run <= pwdata[0];
         if (pwdata[0])
            halted <= 1'b0;
      end else if (halt_wb && run) begin
         run    <= 1'b0;
         halted <= 1'b1;
      end
   end

   always_comb begin
      prdata = '0;
      if (sel_dmem)
         prdata = dmem_rdata;
      else if (sel_ctrl)
         prdata = {14'd0, halted, run};
   end

   fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
      .clk(clk), .rst(rst), .start(start), .stall(hold),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .imem_we(imem_we), .imem_addr(paddr[IMEM_AW-1:0]), .imem_wdata(pwdata),
      .instr_d(instr_d), .pc_d(pc_d));

   decode u_decode (
      .clk(clk), .rst(rst), .instr_d(instr_d), .pc_d(pc_d),
      .stall(hold), .bubble(kill), .flush(flush || start),
      .wb(mw_bus.dst), .de(de_bus.src),
      .rs_sel(rs_sel), .rt_sel(rt_sel), .uses_rt(uses_rt), .err(err));

   hazard_unit u_hazard (
      .clk(clk), .rst(rst), .rs_sel(rs_sel), .rt_sel(rt_sel), .uses_rt(uses_rt),
      .de(de_bus.monitor), .em(em_bus.monitor), .mw(mw_bus.monitor),
      .stall(stall), .bubble(bubble));

   execute u_execute (
      .clk(clk), .rst(rst || start), .de(de_bus.dst), .em(em_bus.src),
      .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush));

   mem_stage #(.DMEM_AW(DMEM_AW)) u_mem (
      .clk(clk), .rst(rst || start), .run(run), .em(em_bus.dst), .wb(mw_bus.src),
      .dmem_we(dmem_we), .dmem_addr(paddr[DMEM_AW-1:0]), .dmem_wdata(pwdata),
      .dmem_rdata(dmem_rdata), .halt_wb(halt_wb));

   // Error response only in an access cycle that follows its setup cycle
   a_pslverr_access: assert property (@(posedge clk) disable iff (rst)
      pslverr |-> penable && $past(psel && !penable))
      else $error("pslverr outside an APB access cycle");

endmodule

//--- design/stage_if.sv
// Pipeline register bundles between decode, execute, memory and write-back
// Each stage writes its own bundle through src, the next stage reads through dst
`timescale 1ns/10ps

interface de_if;
   import proc_pkg::*;
   ctrl_t      ctrl;
   opcode_t    op;
   logic [1:0] func;
   word_t      rs_data;
   word_t      rt_data;
   word_t      imm;       // Already sign extended
   reg_sel_t   dest;
   word_t      pc;

   modport src (output ctrl, op, func, rs_data, rt_data, imm, dest, pc);
   modport dst (input ctrl, op, func, rs_data, rt_data, imm, dest, pc);
   modport monitor (input ctrl, dest);
endinterface

interface em_if;
   import proc_pkg::*;
   ctrl_t    ctrl;
   word_t    alu_result;
   word_t    store_data;
   reg_sel_t dest;

   modport src (output ctrl, alu_result, store_data, dest);
   modport dst (input ctrl, alu_result, store_data, dest);
   modport monitor (input ctrl, dest);
endinterface

interface mw_if;
   import proc_pkg::*;
   logic     reg_write;
   reg_sel_t dest;
   word_t    data;          // Load data or ALU result

   modport src (output reg_write, dest, data);
   modport dst (input reg_write, dest, data);
   modport monitor (input reg_write, dest);
endinterface

//--- proc_top.f
design/proc_pkg.sv
design/stage_if.sv
design/fetch.sv
design/decode.sv
design/hazard_unit.sv
design/execute.sv
design/mem_stage.sv
design/proc_top.sv
bench/proc_top_tb.sv
